//--- common/l2_cfg_pkg.sv
`default_nettype none

package l2_cfg_pkg;

    // Line address layout is {tag, index}
    localparam int ADDR_W = 28;

    // One cache line is four 32-bit words
    localparam int LINE_W = 128;

    // Direct-mapped set selection
    localparam int INDEX_W = 5;

    // Remaining upper address bits
    localparam int TAG_W = ADDR_W - INDEX_W;

    // One line per set
    localparam int NUM_SETS = 1 << INDEX_W;

endpackage

`default_nettype wire

//--- common/l2_line_pkg.sv
`default_nettype none

package l2_line_pkg;

    import l2_cfg_pkg::*;

    // Array entry, 153 bits wide
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] data;
    } l2_line_t;

    // Miss controller states
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WRITEBACK = 2'd1,
        ST_ALLOCATE  = 2'd2,
        ST_FILL      = 2'd3
    } l2_state_e;

    // Which L1 port is being served
    typedef enum logic {
        CLIENT_I = 1'b0,
        CLIENT_D = 1'b1
    } l2_client_e;

endpackage

`default_nettype wire

//--- common/l2_req_if.sv
`timescale 1ns/1ns
`default_nettype none

interface l2_req_if;

    import l2_cfg_pkg::*;
    import l2_line_pkg::*;

    logic              request;
    logic              write;
    l2_client_e        client;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] wdata;

    modport arb (output request, output write, output client, output addr, output wdata);

    // Array only needs the address and the write payload
    modport array (input addr, input wdata);

    modport ctrl (input request, input write, input client, input addr);

endinterface

`default_nettype wire

//--- common/l2_array_if.sv
`timescale 1ns/1ns
`default_nettype none

interface l2_array_if;

    import l2_cfg_pkg::*;

    // Lookup results
    logic              hit;
    logic              victim_valid;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    logic [LINE_W-1:0] rdata;

    // Write controls from the miss controller
    logic              fill_we;
    logic [LINE_W-1:0] fill_data;
    logic              fill_dirty;
    logic              hit_we;

    modport array (
        output hit, output victim_valid, output victim_dirty, output victim_tag,
        output rdata,
        input  fill_we, input fill_data, input fill_dirty, input hit_we
    );

    modport ctrl (
        input  hit, input victim_valid, input victim_dirty, input victim_tag,
        input  rdata,
        output fill_we, output fill_data, output fill_dirty, output hit_we
    );

endinterface

`default_nettype wire

//--- hdl/l2_port_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module l2_port_arbiter (
    input  wire logic                        clk,
    input  wire logic                        proc_reset,
    input  wire logic                        L1i_read_i,
    input  wire logic                        L1d_read_i,
    input  wire logic                        L1d_write_i,
    input  wire logic [l2_cfg_pkg::ADDR_W-1:0] L1i_addr_i,
    input  wire logic [l2_cfg_pkg::ADDR_W-1:0] L1d_addr_i,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] L1d_wdata_i,
    input  wire logic                        busy_i,
    l2_req_if.arb                            req
);

    import l2_line_pkg::*;

    logic       i_req;
    logic       d_req;
    l2_client_e pick;
    l2_client_e lock_client;
    l2_client_e client;
    logic       locked_req;

    assign i_req = L1i_read_i;
    assign d_req = L1d_read_i || L1d_write_i;

    // Fixed priority, instruction side wins a tie
    assign pick = (i_req || !d_req) ? CLIENT_I : CLIENT_D;

    // Sample the pick every idle cycle, so the value at the edge that leaves
    // idle is the one that stays locked
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            lock_client <= CLIENT_I;
        end else if (!busy_i) begin
            lock_client <= pick;
        end
    end

    assign client = busy_i ? lock_client : pick;

    // Steer the granted port onto the request bus
    always_comb begin
        req.client = client;
        req.wdata  = L1d_wdata_i;
        if (client == CLIENT_I) begin
            req.request = i_req;
            req.write   = 1'b0;
            req.addr    = L1i_addr_i;
        end else begin
            req.request = d_req;
            req.write   = L1d_write_i;
            req.addr    = L1d_addr_i;
        end
    end

    assign locked_req = (lock_client == CLIENT_I) ? i_req : d_req;

    // L1 has to keep its request up for the whole miss
    a_lock_held: assert property (@(posedge clk) disable iff (proc_reset)
        busy_i |-> locked_req)
        else $error("locked client dropped its request during a miss");

endmodule

`default_nettype wire

//--- hdl/l2_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module l2_tag_array (
    input  wire logic clk,
    input  wire logic proc_reset,
    l2_req_if.array   req,
    l2_array_if.array arr
);

    import l2_cfg_pkg::*;
    import l2_line_pkg::*;

    l2_line_t mem [NUM_SETS];

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    l2_line_t           entry;

    assign index = req.addr[INDEX_W-1:0];
    assign tag   = req.addr[ADDR_W-1:INDEX_W];
    assign entry = mem[index];

    // Lookup, purely combinational
    assign arr.hit          = entry.valid && (entry.tag == tag);
    assign arr.victim_valid = entry.valid;
    assign arr.victim_dirty = entry.dirty;
    assign arr.victim_tag   = entry.tag;
    assign arr.rdata        = entry.data;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem[i].valid <= 1'b0;
            end
        end else if (arr.fill_we) begin
            // Whole line replaced from memory
            mem[index].valid <= 1'b1;
            mem[index].dirty <= arr.fill_dirty;
            mem[index].tag   <= tag;
            mem[index].data  <= arr.fill_data;
        end else if (arr.hit_we) begin
            // Full-line store from the data port
            mem[index].dirty <= 1'b1;
            mem[index].data  <= req.wdata;
        end
    end

    // Controller may only drive one write source per cycle
    a_one_write: assert property (@(posedge clk) disable iff (proc_reset)
        !(arr.fill_we && arr.hit_we))
        else $error("fill_we and hit_we asserted together");

endmodule

`default_nettype wire

//--- l2_miss_ctrl/l2_miss_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module l2_miss_ctrl (
    input  wire logic                          clk,
    input  wire logic                          proc_reset,
    l2_req_if.ctrl                             req,
    l2_array_if.ctrl                           arr,
    output logic                               busy_o,
    output logic                               L1i_ready_o,
    output logic                               L1d_ready_o,
    output logic                               memi_read_o,
    output logic                               memd_read_o,
    output logic                               memd_write_o,
    output logic [l2_cfg_pkg::ADDR_W-1:0]      memi_addr_o,
    output logic [l2_cfg_pkg::ADDR_W-1:0]      memd_addr_o,
    output logic [l2_cfg_pkg::LINE_W-1:0]      memd_wdata_o,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] memi_rdata_i,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] memd_rdata_i,
    input  wire logic                          memi_ready_i,
    input  wire logic                          memd_ready_i
);

    import l2_cfg_pkg::*;
    import l2_line_pkg::*;

    l2_state_e         state_q;
    l2_state_e         state_d;
    logic              miss;
    logic              need_wb;
    logic              hit_ready;
    logic              chan_ready;
    logic [LINE_W-1:0] chan_rdata;
    logic [LINE_W-1:0] fill_buf_q;

    assign miss    = req.request && !arr.hit;
    assign need_wb = arr.victim_valid && arr.victim_dirty;

    // Allocate runs on the channel of the served client
    assign chan_ready = (req.client == CLIENT_I) ? memi_ready_i : memd_ready_i;
    assign chan_rdata = (req.client == CLIENT_I) ? memi_rdata_i : memd_rdata_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = need_wb ? ST_WRITEBACK : ST_ALLOCATE;
                end
            end
            ST_WRITEBACK: begin
                if (memd_ready_i) begin
                    state_d = ST_ALLOCATE;
                end
            end
            ST_ALLOCATE: begin
                if (chan_ready) begin
                    state_d = ST_FILL;
                end
            end
            default: begin
                // Fill lasts one cycle
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Memory data is only guaranteed while ready is high
    always_ff @(posedge clk) begin
        if (state_q == ST_ALLOCATE && chan_ready) begin
            fill_buf_q <= chan_rdata;
        end
    end

    assign busy_o = (state_q != ST_IDLE);

    // Hits answer in the request cycle
    assign hit_ready   = (state_q == ST_IDLE) && req.request && arr.hit;
    assign L1i_ready_o = hit_ready && (req.client == CLIENT_I);
    assign L1d_ready_o = hit_ready && (req.client == CLIENT_D);

    // Strobes depend on state only, so they stay steady while ready is low
    assign memi_read_o  = (state_q == ST_ALLOCATE) && (req.client == CLIENT_I);
    assign memd_read_o  = (state_q == ST_ALLOCATE) && (req.client == CLIENT_D);
    assign memd_write_o = (state_q == ST_WRITEBACK);

    assign memi_addr_o = req.addr;

    // Writeback goes to the victim's own location
    assign memd_addr_o  = (state_q == ST_WRITEBACK) ?
                          {arr.victim_tag, req.addr[INDEX_W-1:0]} : req.addr;
    assign memd_wdata_o = arr.rdata;

    // Array writes
    assign arr.fill_we    = (state_q == ST_FILL);
    assign arr.fill_data  = fill_buf_q;
    // Filled lines start clean, a write miss then completes as a write hit
    assign arr.fill_dirty = 1'b0;
    assign arr.hit_we     = hit_ready && req.write;

    a_memd_excl: assert property (@(posedge clk) disable iff (proc_reset)
        !(memd_read_o && memd_write_o))
        else $error("memd read and write strobes high together");

endmodule

`default_nettype wire

//--- hdl/l2cache.sv
`timescale 1ns/1ns
`default_nettype none

module l2cache (
    input  wire logic                          clk,
    input  wire logic                          proc_reset,

    // Instruction L1
    input  wire logic                          L1i_read_i,
    input  wire logic [l2_cfg_pkg::ADDR_W-1:0] L1i_addr_i,
    output logic [l2_cfg_pkg::LINE_W-1:0]      L1i_rdata_o,
    output logic                               L1i_ready_o,

    // Data L1
    input  wire logic                          L1d_read_i,
    input  wire logic                          L1d_write_i,
    input  wire logic [l2_cfg_pkg::ADDR_W-1:0] L1d_addr_i,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] L1d_wdata_i,
    output logic [l2_cfg_pkg::LINE_W-1:0]      L1d_rdata_o,
    output logic                               L1d_ready_o,

    // Instruction memory channel, read only
    output logic                               memi_read_o,
    output logic                               memi_write_o,
    output logic [l2_cfg_pkg::ADDR_W-1:0]      memi_addr_o,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] memi_rdata_i,
    input  wire logic                          memi_ready_i,

    // Data memory channel, fills and all writebacks
    output logic                               memd_read_o,
    output logic                               memd_write_o,
    output logic [l2_cfg_pkg::ADDR_W-1:0]      memd_addr_o,
    output logic [l2_cfg_pkg::LINE_W-1:0]      memd_wdata_o,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] memd_rdata_i,
    input  wire logic                          memd_ready_i
);

    logic busy;

    l2_req_if   req_bus ();
    l2_array_if arr_bus ();

    l2_port_arbiter u_arb (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .L1i_read_i  (L1i_read_i),
        .L1d_read_i  (L1d_read_i),
        .L1d_write_i (L1d_write_i),
        .L1i_addr_i  (L1i_addr_i),
        .L1d_addr_i  (L1d_addr_i),
        .L1d_wdata_i (L1d_wdata_i),
        .busy_i      (busy),
        .req         (req_bus.arb)
    );

    l2_tag_array u_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .req        (req_bus.array),
        .arr        (arr_bus.array)
    );

    l2_miss_ctrl u_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .req          (req_bus.ctrl),
        .arr          (arr_bus.ctrl),
        .busy_o       (busy),
        .L1i_ready_o  (L1i_ready_o),
        .L1d_ready_o  (L1d_ready_o),
        .memi_read_o  (memi_read_o),
        .memd_read_o  (memd_read_o),
        .memd_write_o (memd_write_o),
        .memi_addr_o  (memi_addr_o),
        .memd_addr_o  (memd_addr_o),
        .memd_wdata_o (memd_wdata_o),
        .memi_rdata_i (memi_rdata_i),
        .memd_rdata_i (memd_rdata_i),
        .memi_ready_i (memi_ready_i),
        .memd_ready_i (memd_ready_i)
    );

    // Both ports see the looked-up line, ready tells which one it is for
    assign L1i_rdata_o = arr_bus.rdata;
    assign L1d_rdata_o = arr_bus.rdata;

    // Dirty data never leaves on the instruction channel
    assign memi_write_o = 1'b0;

endmodule

`default_nettype wire

//--- tb/l2_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module l2_mem_model (
    input  wire logic                          clk,
    input  wire logic                          proc_reset,
    input  wire logic                          memi_read_i,
    input  wire logic [l2_cfg_pkg::ADDR_W-1:0] memi_addr_i,
    output logic [l2_cfg_pkg::LINE_W-1:0]      memi_rdata_o,
    output logic                               memi_ready_o,
    input  wire logic                          memd_read_i,
    input  wire logic                          memd_write_i,
    input  wire logic [l2_cfg_pkg::ADDR_W-1:0] memd_addr_i,
    input  wire logic [l2_cfg_pkg::LINE_W-1:0] memd_wdata_i,
    output logic [l2_cfg_pkg::LINE_W-1:0]      memd_rdata_o,
    output logic                               memd_ready_o,
    output int                                 memi_reads_o,
    output int                                 memd_reads_o,
    output int                                 memd_writes_o,
    output logic [l2_cfg_pkg::ADDR_W-1:0]      last_wb_addr_o,
    output logic [l2_cfg_pkg::LINE_W-1:0]      last_wb_data_o
);

    import l2_cfg_pkg::*;

    // Ready rises on the third edge after the strobe
    localparam logic [1:0] WAIT_EDGES = 2'd2;

    // Only written lines are stored, the rest read as the address pattern
    logic [LINE_W-1:0] store [logic [ADDR_W-1:0]];
    logic [1:0]        i_wait = 2'd0;
    logic [1:0]        d_wait = 2'd0;
    logic              i_ready_q = 1'b0;
    logic              d_ready_q = 1'b0;
    int                i_reads = 0;
    int                d_reads = 0;
    int                d_writes = 0;
    logic [ADDR_W-1:0] wb_addr_q = '0;
    logic [LINE_W-1:0] wb_data_q = '0;

    function automatic logic [LINE_W-1:0] addr_pattern(input logic [ADDR_W-1:0] a);
        return {4{4'h0, a}};
    endfunction

    always_comb begin
        memi_rdata_o = store.exists(memi_addr_i) ? store[memi_addr_i]
                                                 : addr_pattern(memi_addr_i);
        memd_rdata_o = store.exists(memd_addr_i) ? store[memd_addr_i]
                                                 : addr_pattern(memd_addr_i);
    end

    always @(posedge clk) begin
        if (proc_reset) begin
            i_wait    <= 2'd0;
            i_ready_q <= 1'b0;
            i_reads   <= 0;
        end else if (i_ready_q) begin
            i_ready_q <= 1'b0;
            i_wait    <= 2'd0;
            i_reads   <= i_reads + 1;
        end else if (memi_read_i) begin
            if (i_wait == WAIT_EDGES) begin
                i_ready_q <= 1'b1;
            end else begin
                i_wait <= i_wait + 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (proc_reset) begin
            d_wait    <= 2'd0;
            d_ready_q <= 1'b0;
            d_reads   <= 0;
            d_writes  <= 0;
        end else if (d_ready_q) begin
            d_ready_q <= 1'b0;
            d_wait    <= 2'd0;
            if (memd_write_i) begin
                store[memd_addr_i] = memd_wdata_i;
                wb_addr_q <= memd_addr_i;
                wb_data_q <= memd_wdata_i;
                d_writes  <= d_writes + 1;
            end else begin
                d_reads <= d_reads + 1;
            end
        end else if (memd_read_i || memd_write_i) begin
            if (d_wait == WAIT_EDGES) begin
                d_ready_q <= 1'b1;
            end else begin
                d_wait <= d_wait + 2'd1;
            end
        end
    end

    assign memi_ready_o   = i_ready_q;
    assign memd_ready_o   = d_ready_q;
    assign memi_reads_o   = i_reads;
    assign memd_reads_o   = d_reads;
    assign memd_writes_o  = d_writes;
    assign last_wb_addr_o = wb_addr_q;
    assign last_wb_data_o = wb_data_q;

endmodule

`default_nettype wire

//--- tb/l2cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module l2cache_tb;

    import l2_cfg_pkg::*;

    // Each test needs a few dozen cycles, this leaves a wide margin
    localparam int MAX_CYCLES   = 3000;
    localparam int SAMPLE_DELAY = 3;

    logic              clk = 1'b0;
    logic              proc_reset;
    logic              l1i_read;
    logic [ADDR_W-1:0] l1i_addr;
    logic [LINE_W-1:0] l1i_rdata;
    logic              l1i_ready;
    logic              l1d_read;
    logic              l1d_write;
    logic [ADDR_W-1:0] l1d_addr;
    logic [LINE_W-1:0] l1d_wdata;
    logic [LINE_W-1:0] l1d_rdata;
    logic              l1d_ready;
    logic              memi_read;
    logic              memi_write;
    logic [ADDR_W-1:0] memi_addr;
    logic [LINE_W-1:0] memi_rdata;
    logic              memi_ready;
    logic              memd_read;
    logic              memd_write;
    logic [ADDR_W-1:0] memd_addr;
    logic [LINE_W-1:0] memd_wdata;
    logic [LINE_W-1:0] memd_rdata;
    logic              memd_ready;
    int                memi_reads;
    int                memd_reads;
    int                memd_writes;
    logic [ADDR_W-1:0] last_wb_addr;
    logic [LINE_W-1:0] last_wb_data;

    int                value_errors = 0;
    int                proto_errors = 0;
    int                cycles = 0;
    logic [31:0]       lfsr_state = 32'hb945;
    logic [ADDR_W-1:0] written_addr;
    logic [LINE_W-1:0] written_line;

    l2cache dut0 (
        .clk (clk), .proc_reset (proc_reset),
        .L1i_read_i (l1i_read), .L1i_addr_i (l1i_addr),
        .L1i_rdata_o (l1i_rdata), .L1i_ready_o (l1i_ready),
        .L1d_read_i (l1d_read), .L1d_write_i (l1d_write), .L1d_addr_i (l1d_addr),
        .L1d_wdata_i (l1d_wdata), .L1d_rdata_o (l1d_rdata), .L1d_ready_o (l1d_ready),
        .memi_read_o (memi_read), .memi_write_o (memi_write), .memi_addr_o (memi_addr),
        .memi_rdata_i (memi_rdata), .memi_ready_i (memi_ready),
        .memd_read_o (memd_read), .memd_write_o (memd_write), .memd_addr_o (memd_addr),
        .memd_wdata_o (memd_wdata), .memd_rdata_i (memd_rdata), .memd_ready_i (memd_ready)
    );

    l2_mem_model mem0 (
        .clk (clk), .proc_reset (proc_reset),
        .memi_read_i (memi_read), .memi_addr_i (memi_addr),
        .memi_rdata_o (memi_rdata), .memi_ready_o (memi_ready),
        .memd_read_i (memd_read), .memd_write_i (memd_write), .memd_addr_i (memd_addr),
        .memd_wdata_i (memd_wdata), .memd_rdata_o (memd_rdata), .memd_ready_o (memd_ready),
        .memi_reads_o (memi_reads), .memd_reads_o (memd_reads),
        .memd_writes_o (memd_writes), .last_wb_addr_o (last_wb_addr),
        .last_wb_data_o (last_wb_data)
    );

    always #4 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [LINE_W-1:0] memory_pattern(input logic [ADDR_W-1:0] a);
        return {4{4'h0, a}};
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [INDEX_W-1:0] index);
        return {tag, index};
    endfunction

    task automatic next_random_line(output logic [LINE_W-1:0] v);
        for (int b = 0; b < LINE_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[b] = lfsr_state[0];
        end
    endtask

    task automatic check_line(input string what, input logic [LINE_W-1:0] got,
                              input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // Request is held through the edge on which ready is seen high
    task automatic fetch_i(input logic [ADDR_W-1:0] addr, output logic [LINE_W-1:0] data);
        @(negedge clk);
        l1i_read = 1'b1;
        l1i_addr = addr;
        #SAMPLE_DELAY;
        while (!l1i_ready) begin
            @(negedge clk);
            #SAMPLE_DELAY;
        end
        data = l1i_rdata;
        @(negedge clk);
        l1i_read = 1'b0;
    endtask

    task automatic access_d(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [LINE_W-1:0] wdata, output logic [LINE_W-1:0] data);
        @(negedge clk);
        l1d_read  = !write;
        l1d_write = write;
        l1d_addr  = addr;
        l1d_wdata = wdata;
        #SAMPLE_DELAY;
        while (!l1d_ready) begin
            @(negedge clk);
            #SAMPLE_DELAY;
        end
        data = l1d_rdata;
        @(negedge clk);
        l1d_read  = 1'b0;
        l1d_write = 1'b0;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        #SAMPLE_DELAY;
        check_count("strobes and readies after reset",
                    int'({memi_read, memi_write, memd_read, memd_write, l1i_ready, l1d_ready}), 0);
    endtask

    task automatic test_i_miss_then_hit();
        logic [ADDR_W-1:0] a;
        logic [LINE_W-1:0] data;
        int                reads0;
        a = make_addr(23'h01234, 5'd3);
        reads0 = memi_reads;
        fetch_i(a, data);
        check_line("I miss data", data, memory_pattern(a));
        check_count("memi reads after I miss", memi_reads, reads0 + 1);
        fetch_i(a, data);
        check_line("I hit data", data, memory_pattern(a));
        check_count("memi reads after I hit", memi_reads, reads0 + 1);
    endtask

    task automatic test_d_write_allocate();
        logic [LINE_W-1:0] data;
        int                rd0;
        int                wr0;
        rd0 = memd_reads;
        wr0 = memd_writes;
        written_addr = make_addr(23'h000a5, 5'd7);
        next_random_line(written_line);
        access_d(1'b1, written_addr, written_line, data);
        check_count("memd reads after write miss", memd_reads, rd0 + 1);
        check_count("memd writes after write miss", memd_writes, wr0);
        access_d(1'b0, written_addr, '0, data);
        check_line("D read after write", data, written_line);
        check_count("memd reads after read hit", memd_reads, rd0 + 1);
        check_count("memd writes after read hit", memd_writes, wr0);
    endtask

    task automatic test_dirty_eviction();
        logic [ADDR_W-1:0] other;
        logic [LINE_W-1:0] data;
        int                rd0;
        int                wr0;
        other = make_addr(23'h001f0, 5'd7);
        rd0 = memd_reads;
        wr0 = memd_writes;
        access_d(1'b0, other, '0, data);
        check_line("D read of conflicting line", data, memory_pattern(other));
        check_count("memd writes after eviction", memd_writes, wr0 + 1);
        check_count("memd reads after eviction", memd_reads, rd0 + 1);
        if (last_wb_addr !== written_addr) begin
            $display("ERR %0t: writeback address %h, expected %h",
                     $time, last_wb_addr, written_addr);
            value_errors++;
        end
        check_line("writeback data", last_wb_data, written_line);
        access_d(1'b0, written_addr, '0, data);
        check_line("D read of evicted line", data, written_line);
        check_count("memd writes after re-read", memd_writes, wr0 + 1);
    endtask

    task automatic test_i_miss_over_dirty();
        logic [ADDR_W-1:0] victim;
        logic [ADDR_W-1:0] target;
        logic [LINE_W-1:0] line;
        logic [LINE_W-1:0] data;
        int                ird0;
        int                drd0;
        int                wr0;
        victim = make_addr(23'h00333, 5'd9);
        target = make_addr(23'h00444, 5'd9);
        next_random_line(line);
        access_d(1'b1, victim, line, data);
        ird0 = memi_reads;
        drd0 = memd_reads;
        wr0 = memd_writes;
        fetch_i(target, data);
        check_line("I fetch over dirty line", data, memory_pattern(target));
        check_count("memd writes after I miss", memd_writes, wr0 + 1);
        check_count("memi reads after I miss", memi_reads, ird0 + 1);
        check_count("memd reads after I miss", memd_reads, drd0);
        if (last_wb_addr !== victim) begin
            $display("ERR %0t: writeback address %h, expected %h", $time, last_wb_addr, victim);
            value_errors++;
        end
        check_line("writeback data", last_wb_data, line);
    endtask

    task automatic test_simultaneous();
        logic [ADDR_W-1:0] ia;
        logic [ADDR_W-1:0] da;
        logic [LINE_W-1:0] idata;
        logic [LINE_W-1:0] ddata;
        time               i_done;
        time               d_done;
        ia = make_addr(23'h00555, 5'd12);
        da = make_addr(23'h00666, 5'd13);
        fork
            begin
                fetch_i(ia, idata);
                i_done = $time;
            end
            begin
                access_d(1'b0, da, '0, ddata);
                d_done = $time;
            end
        join
        check_line("I data with both ports busy", idata, memory_pattern(ia));
        check_line("D data with both ports busy", ddata, memory_pattern(da));
        if (i_done >= d_done) begin
            $display("ERR %0t: data port finished at %0t, before instruction port at %0t",
                     $time, d_done, i_done);
            value_errors++;
        end
    endtask

    // Protocol monitor, sampled mid-cycle
    always @(negedge clk) begin
        #SAMPLE_DELAY;
        if (!proc_reset && memi_write) begin
            $display("Instruction channel write strobe went high at %0t", $time);
            proto_errors++;
        end
        if (!proc_reset && l1i_ready && l1d_ready) begin
            $display("Both L1 ready outputs were high together at %0t", $time);
            proto_errors++;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a request never completed", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        proc_reset = 1'b1;
        l1i_read   = 1'b0;
        l1i_addr   = '0;
        l1d_read   = 1'b0;
        l1d_write  = 1'b0;
        l1d_addr   = '0;
        l1d_wdata  = '0;
        repeat (10) @(negedge clk);
        proc_reset = 1'b0;
        test_reset_state();
        test_i_miss_then_hit();
        test_d_write_allocate();
        test_dirty_eviction();
        test_i_miss_over_dirty();
        test_simultaneous();
        @(negedge clk);
        $display("Summary: %0d wrong values, %0d protocol errors", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- l2cache.f
common/l2_cfg_pkg.sv
common/l2_line_pkg.sv
common/l2_req_if.sv
common/l2_array_if.sv
hdl/l2_port_arbiter.sv
hdl/l2_tag_array.sv
l2_miss_ctrl/l2_miss_ctrl.sv
hdl/l2cache.sv
tb/l2_mem_model.sv
tb/l2cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the L2 cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f l2cache.f --top-module l2cache_tb -o l2cache_sim \
    && ./obj_dir/l2cache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }

cat sim.log
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
